//--- hw/noc_pkg.sv
package noc_pkg;

    localparam int NUM_NODES  = 4;
    localparam int NODE_BITS  = 2;
    localparam int MAX_FLITS  = 8;
    localparam int LEN_BITS   = 4;
    localparam int DESC_DEPTH = 8;
    localparam int RING_DEPTH = 4;
    localparam int CYCLE_BITS = 16;

    // one queued packet, length counted in flits
    typedef struct packed
    {
        logic [NODE_BITS-1:0] dst;
        logic [LEN_BITS-1:0]  len;
    } desc_t;

    typedef struct packed
    {
        logic [NODE_BITS-1:0] src;
        logic [NODE_BITS-1:0] dst;
        logic                 head;
        logic                 tail;
    } flit_t;

    // command broadcast by the control FSM to all routers
    typedef enum logic [1:0]
    {
        PH_IDLE  = 2'd0,
        PH_STAGE = 2'd1,   // staging regs move into downstream buffers
        PH_ZERO  = 2'd2,   // decide
        PH_ONE   = 2'd3    // commit
    } phase_t;

endpackage

//--- hw/payload_fifo.sv
`timescale 1ns/10ps

module payload_fifo #(
    parameter type T_PAYLOAD = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       push_i,
    input  T_PAYLOAD                   push_data_i,
    input  logic                       pop_i,
    output T_PAYLOAD                   head_o,
    output logic                       empty_o,
    output logic [$clog2(DEPTH+1)-1:0] free_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH+1);

    T_PAYLOAD         mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             full;

    assign full    = (count == CNT_W'(DEPTH));
    assign empty_o = (count == '0);
    assign free_o  = CNT_W'(DEPTH) - count;
    assign head_o  = mem[rd_ptr];   // first-word fall-through

    always_ff @(posedge clk)
    begin
        if (push_i)
            mem[wr_ptr] <= push_data_i;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push_i)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            if (pop_i)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            if (push_i && !pop_i)
                count <= count + 1'b1;
            else if (pop_i && !push_i)
                count <= count - 1'b1;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        push_i |-> (!full || pop_i))
        else $error("payload_fifo: push into full fifo");

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        pop_i |-> !empty_o)
        else $error("payload_fifo: pop from empty fifo");

endmodule

//--- hw/traffic_source.sv
`timescale 1ns/10ps

module traffic_source
    import noc_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 fill_i,
    input  desc_t                fill_desc_i,
    input  logic [NODE_BITS-1:0] node_id_i,
    input  logic                 inj_take_i,
    output logic                 inj_valid_o,
    output flit_t                inj_flit_o,
    output logic                 empty_o
);

    desc_t               cur_desc;
    logic                desc_empty;
    logic [LEN_BITS-1:0] remain;    // flits owed after the head, zero before it
    logic                is_head;
    logic                is_tail;
    logic                pop_desc;

    payload_fifo #(
        .T_PAYLOAD (desc_t),
        .DEPTH     (DESC_DEPTH)
    ) desc_q (
        .clk         (clk),
        .reset       (reset),
        .push_i      (fill_i),
        .push_data_i (fill_desc_i),
        .pop_i       (pop_desc),
        .head_o      (cur_desc),
        .empty_o     (desc_empty),
        .free_o      ()
    );

    assign is_head  = (remain == '0);
    assign is_tail  = is_head ? (cur_desc.len == LEN_BITS'(1)) : (remain == LEN_BITS'(1));
    assign pop_desc = inj_take_i && is_tail;   // packet done, next descriptor

    assign inj_valid_o     = !desc_empty;
    assign inj_flit_o.src  = node_id_i;
    assign inj_flit_o.dst  = cur_desc.dst;
    assign inj_flit_o.head = is_head;
    assign inj_flit_o.tail = is_tail;

    // a partial packet always keeps its descriptor queued
    assign empty_o = desc_empty && is_head;

    always_ff @(posedge clk)
    begin
        if (reset)
            remain <= '0;
        else if (inj_take_i)
        begin
            if (is_tail)
                remain <= '0;
            else if (is_head)
                remain <= cur_desc.len - 1'b1;
            else
                remain <= remain - 1'b1;
        end
    end

    a_fill_len: assert property (@(posedge clk) disable iff (reset)
        fill_i |-> (fill_desc_i.len >= 1 && fill_desc_i.len <= MAX_FLITS))
        else $error("traffic_source: packet length out of range");

    // router may only take what is offered
    a_take_valid: assert property (@(posedge clk) disable iff (reset)
        inj_take_i |-> inj_valid_o)
        else $error("traffic_source: take without a valid flit");

endmodule

//--- hw/ring_router.sv
`timescale 1ns/10ps

module ring_router
    import noc_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  phase_t                 phase_i,
    input  logic [NODE_BITS-1:0]   node_id_i,
    input  logic                   ring_valid_i,
    input  flit_t                  ring_flit_i,
    output logic [$clog2(RING_DEPTH+1)-1:0] ring_space_o,
    input  logic [$clog2(RING_DEPTH+1)-1:0] next_space_i,
    input  logic                   inj_valid_i,
    input  flit_t                  inj_flit_i,
    output logic                   inj_take_o,
    output logic                   out_valid_o,
    output flit_t                  out_flit_o,
    output logic                   eject_valid_o,
    output logic [NODE_BITS-1:0]   eject_src_o,
    output logic                   eject_head_o,
    output logic                   eject_tail_o,
    output logic                   done_o
);

    flit_t buf_head;
    logic  buf_empty;
    logic  buf_push;
    logic  buf_pop;

    // action picked in phase 0, applied in phase 1
    logic  dec_eject;
    logic  dec_fwd;
    logic  dec_inj;

    logic  head_local;
    logic  can_fwd;
    logic  can_inj;

    payload_fifo #(
        .T_PAYLOAD (flit_t),
        .DEPTH     (RING_DEPTH)
    ) ring_buf (
        .clk         (clk),
        .reset       (reset),
        .push_i      (buf_push),
        .push_data_i (ring_flit_i),
        .pop_i       (buf_pop),
        .head_o      (buf_head),
        .empty_o     (buf_empty),
        .free_o      (ring_space_o)
    );

    assign buf_push = (phase_i == PH_STAGE) && ring_valid_i;
    assign buf_pop  = (phase_i == PH_ONE) && (dec_eject || dec_fwd);

    assign head_local = !buf_empty && (buf_head.dst == node_id_i);
    assign can_fwd    = !buf_empty && !head_local && (next_space_i != '0);
    // bubble rule: keep one slot downstream for ring traffic
    assign can_inj    = buf_empty && inj_valid_i && (next_space_i >= 2);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            dec_eject <= 1'b0;
            dec_fwd   <= 1'b0;
            dec_inj   <= 1'b0;
        end
        else if (phase_i == PH_ZERO)
        begin
            dec_eject <= head_local;
            dec_fwd   <= can_fwd;
            dec_inj   <= can_inj;
        end
    end

    // staging register toward the next node
    always_ff @(posedge clk)
    begin
        if (reset)
            out_valid_o <= 1'b0;
        else if (phase_i == PH_STAGE)
            out_valid_o <= 1'b0;    // handed over this clock
        else if (phase_i == PH_ONE)
            out_valid_o <= dec_fwd || dec_inj;
    end

    always_ff @(posedge clk)
    begin
        if (phase_i == PH_ONE)
            out_flit_o <= dec_fwd ? buf_head : inj_flit_i;
    end

    assign inj_take_o    = (phase_i == PH_ONE) && dec_inj;
    assign eject_valid_o = (phase_i == PH_ONE) && dec_eject;
    assign eject_src_o   = buf_head.src;
    assign eject_head_o  = buf_head.head;
    assign eject_tail_o  = buf_head.tail;

    assign done_o = buf_empty && !out_valid_o;

    a_eject_dst: assert property (@(posedge clk) disable iff (reset)
        eject_valid_o |-> (buf_head.dst == node_id_i))
        else $error("ring_router: ejected flit addressed to another node");

endmodule

//--- hw/sim_control.sv
`timescale 1ns/10ps

module sim_control
    import noc_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start_i,
    input  logic [NUM_NODES-1:0]  done_i,
    output phase_t                phase_o,
    output logic                  running_o,
    output logic                  is_end_o,
    output logic [CYCLE_BITS-1:0] in_cycle_o
);

    typedef enum logic [2:0]
    {
        S_IDLE,
        S_PRIME,
        S_STAGE,
        S_PH0,
        S_PH1,
        S_CHECK,
        S_END
    } ctrl_state_t;

    ctrl_state_t state;

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= S_IDLE;
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (start_i)
                        state <= S_PRIME;
                end
                S_PRIME: state <= S_STAGE;
                S_STAGE: state <= S_PH0;
                S_PH0:   state <= S_PH1;
                S_PH1:   state <= S_CHECK;
                S_CHECK:
                begin
                    if (&done_i)
                        state <= S_END;   // network drained
                    else
                        state <= S_STAGE;
                end
                default: state <= S_END;  // stays here until reset
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            in_cycle_o <= '0;
        else if (state == S_PH1)
            in_cycle_o <= in_cycle_o + 1'b1;
    end

    always_comb
    begin
        case (state)
            S_STAGE: phase_o = PH_STAGE;
            S_PH0:   phase_o = PH_ZERO;
            S_PH1:   phase_o = PH_ONE;
            default: phase_o = PH_IDLE;
        endcase
    end

    assign running_o = (state != S_IDLE) && (state != S_END);
    assign is_end_o  = (state == S_END);

    a_end_frozen: assert property (@(posedge clk) disable iff (reset)
        is_end_o |=> (is_end_o && $stable(in_cycle_o)))
        else $error("sim_control: cycle count moved after end");

endmodule

//--- hw/noc_top.sv
`timescale 1ns/10ps

module noc_top
    import noc_pkg::*;
(
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                fill_i,
    input  logic [NODE_BITS-1:0]                fill_src_i,
    input  logic [NODE_BITS-1:0]                fill_dst_i,
    input  logic [LEN_BITS-1:0]                 fill_len_i,
    input  logic                                start_i,
    output logic                                running_o,
    output logic                                is_end_o,
    output logic [CYCLE_BITS-1:0]               in_cycle_o,
    output logic [NUM_NODES-1:0]                eject_valid_o,
    output logic [NUM_NODES-1:0][NODE_BITS-1:0] eject_src_o,
    output logic [NUM_NODES-1:0]                eject_head_o,
    output logic [NUM_NODES-1:0]                eject_tail_o
);

    phase_t                 phase;
    desc_t                  fill_desc;
    logic                   fill_open;
    logic [NUM_NODES-1:0]   done;
    logic [NUM_NODES-1:0]   router_done;
    logic [NUM_NODES-1:0]   src_empty;
    logic [NUM_NODES-1:0]   inj_valid;
    logic [NUM_NODES-1:0]   inj_take;
    flit_t                  inj_flit [NUM_NODES];
    logic [NUM_NODES-1:0]   ring_valid;    // staging output of node i
    flit_t                  ring_flit [NUM_NODES];
    logic [$clog2(RING_DEPTH+1)-1:0] space [NUM_NODES];

    assign fill_open     = !running_o && !is_end_o;   // fill only before start
    assign fill_desc.dst = fill_dst_i;
    assign fill_desc.len = fill_len_i;

    sim_control ctrl (
        .clk        (clk),
        .reset      (reset),
        .start_i    (start_i),
        .done_i     (done),
        .phase_o    (phase),
        .running_o  (running_o),
        .is_end_o   (is_end_o),
        .in_cycle_o (in_cycle_o)
    );

    for (genvar i = 0; i < NUM_NODES; i++)
    begin : g_node
        traffic_source src (
            .clk         (clk),
            .reset       (reset),
            .fill_i      (fill_i && fill_open && (fill_src_i == NODE_BITS'(i))),
            .fill_desc_i (fill_desc),
            .node_id_i   (NODE_BITS'(i)),
            .inj_take_i  (inj_take[i]),
            .inj_valid_o (inj_valid[i]),
            .inj_flit_o  (inj_flit[i]),
            .empty_o     (src_empty[i])
        );

        // node i feeds node i+1, space flows back the other way
        ring_router rtr (
            .clk           (clk),
            .reset         (reset),
            .phase_i       (phase),
            .node_id_i     (NODE_BITS'(i)),
            .ring_valid_i  (ring_valid[(i+NUM_NODES-1)%NUM_NODES]),
            .ring_flit_i   (ring_flit[(i+NUM_NODES-1)%NUM_NODES]),
            .ring_space_o  (space[i]),
            .next_space_i  (space[(i+1)%NUM_NODES]),
            .inj_valid_i   (inj_valid[i]),
            .inj_flit_i    (inj_flit[i]),
            .inj_take_o    (inj_take[i]),
            .out_valid_o   (ring_valid[i]),
            .out_flit_o    (ring_flit[i]),
            .eject_valid_o (eject_valid_o[i]),
            .eject_src_o   (eject_src_o[i]),
            .eject_head_o  (eject_head_o[i]),
            .eject_tail_o  (eject_tail_o[i]),
            .done_o        (router_done[i])
        );

        assign done[i] = router_done[i] && src_empty[i];
    end

endmodule

//--- sim/tb_noc.sv
`timescale 1ns/10ps

module tb_noc
    import noc_pkg::*;
();

    localparam int PKTS_PER_SRC  = 6;
    localparam int NUM_PKTS      = PKTS_PER_SRC * NUM_NODES;
    localparam int NUM_PAIRS     = NUM_NODES * NUM_NODES;
    localparam int LEN_RAND_BITS = 3;    // len - 1 fits in 3 bits
    localparam int CLK_NS        = 20;
    localparam int RESET_CLKS    = 16;

    logic                                clk;
    logic                                reset;
    logic                                fill;
    logic [NODE_BITS-1:0]                fill_src;
    logic [NODE_BITS-1:0]                fill_dst;
    logic [LEN_BITS-1:0]                 fill_len;
    logic                                start;
    logic                                running;
    logic                                is_end;
    logic [CYCLE_BITS-1:0]               in_cycle;
    logic [NUM_NODES-1:0]                eject_valid;
    logic [NUM_NODES-1:0][NODE_BITS-1:0] eject_src;
    logic [NUM_NODES-1:0]                eject_head;
    logic [NUM_NODES-1:0]                eject_tail;

    // scoreboard indexed by src * NUM_NODES + dst
    int exp_len [NUM_PAIRS][$];
    int flit_cnt [NUM_PAIRS];
    bit in_pkt [NUM_PAIRS];
    int exp_tails [NUM_NODES];
    int seen_tails [NUM_NODES];
    int filled [NUM_NODES];

    int                    errors;
    int                    checks;
    int                    received;
    int                    total_flits;
    int                    since_step;
    bit                    was_running;
    bit                    end_seen;
    logic [CYCLE_BITS-1:0] last_cycle;
    logic [15:0]           lfsr;
    longint                limit_ns;

    noc_top dut0 (
        .clk           (clk),
        .reset         (reset),
        .fill_i        (fill),
        .fill_src_i    (fill_src),
        .fill_dst_i    (fill_dst),
        .fill_len_i    (fill_len),
        .start_i       (start),
        .running_o     (running),
        .is_end_o      (is_end),
        .in_cycle_o    (in_cycle),
        .eject_valid_o (eject_valid),
        .eject_src_o   (eject_src),
        .eject_head_o  (eject_head),
        .eject_tail_o  (eject_tail)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #(CLK_NS/2) clk = ~clk;
    end

    // galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0])
            return (s >> 1) ^ 16'hB400;
        else
            return s >> 1;
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int k = 0; k < n; k++)
        begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    task automatic compare_value(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual)
        else
        begin
            errors++;
            $display("FAILED %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic fill_packet(input int src, input int dst, input int len);
        @(negedge clk);
        fill     = 1'b1;
        fill_src = NODE_BITS'(src);
        fill_dst = NODE_BITS'(dst);
        fill_len = LEN_BITS'(len);
        exp_len[src*NUM_NODES+dst].push_back(len);
        exp_tails[dst]++;
        total_flits += len;
        @(negedge clk);
        fill = 1'b0;
    endtask

    task automatic fill_random_traffic();
        int src;
        int dst;
        int len;
        for (int p = 0; p < NUM_PKTS; p++)
        begin
            take_bits(NODE_BITS, src);
            while (filled[src] == PKTS_PER_SRC)
                src = (src + 1) % NUM_NODES;   // source already full so try the next
            take_bits(NODE_BITS, dst);
            take_bits(LEN_RAND_BITS, len);
            filled[src]++;
            fill_packet(src, dst, len + 1);
        end
    endtask

    task automatic check_ejections();
        int src;
        int pair;
        int expected;
        for (int n = 0; n < NUM_NODES; n++)
        begin
            if (eject_valid[n])
            begin
                src  = int'(eject_src[n]);
                pair = src * NUM_NODES + n;
                if (eject_head[n])
                begin
                    if (exp_len[pair].size() == 0)
                        report_problem($sformatf("node %0d got a packet from %0d not sent there",
                                                 n, src));
                    if (in_pkt[pair])
                        report_problem($sformatf("node %0d got a head from %0d before the tail",
                                                 n, src));
                    in_pkt[pair]   = 1'b1;
                    flit_cnt[pair] = 0;
                end
                else if (!in_pkt[pair])
                    report_problem($sformatf("node %0d got a body flit from %0d without a head",
                                             n, src));
                flit_cnt[pair]++;
                if (eject_tail[n])
                begin
                    if (exp_len[pair].size() != 0)
                    begin
                        expected = exp_len[pair].pop_front();
                        compare_value($sformatf("len_src%0d_dst%0d", src, n), expected,
                                      flit_cnt[pair]);
                    end
                    in_pkt[pair] = 1'b0;
                    seen_tails[n]++;
                    received++;
                end
            end
        end
    endtask

    task automatic track_cycle_count();
        if (running)
        begin
            if (!was_running)
                since_step = 0;
            else
                since_step++;
            if (in_cycle != last_cycle)
            begin
                compare_value("cycle_step_clocks", 4, since_step);
                compare_value("cycle_step_value", int'(last_cycle) + 1, int'(in_cycle));
                since_step = 0;
            end
            else if (since_step == 5)
                compare_value("cycle_step_clocks", 4, since_step);   // counter stalled
        end
        if (is_end && !end_seen)
        begin
            end_seen = 1'b1;
            compare_value("packets_at_end", NUM_PKTS, received);
        end
        was_running = running;
        last_cycle  = in_cycle;
    endtask

    // outputs settle long before the falling edge
    always @(negedge clk)
    begin
        if (!reset)
        begin
            check_ejections();
            track_cycle_count();
        end
    end

    a_idle_no_eject: assert property (@(posedge clk) disable iff (reset)
        !running |-> (eject_valid == '0))
        else report_problem("eject_valid_o pulsed while the run was not active");

    a_end_holds: assert property (@(posedge clk) disable iff (reset)
        is_end |=> (is_end && !running && $stable(in_cycle)))
        else report_problem("state changed after is_end_o rose");

    a_end_not_running: assert property (@(posedge clk) disable iff (reset)
        !(is_end && running))
        else report_problem("running_o and is_end_o high together");

    a_cycle_by_one: assert property (@(posedge clk) disable iff (reset)
        (in_cycle != $past(in_cycle)) |-> (in_cycle == $past(in_cycle) + 1'b1))
        else report_problem("in_cycle_o moved by more than one");

    initial
    begin : watchdog
        wait (limit_ns != 0);
        #(limit_ns - longint'($time));
        $display("timeout: network did not drain within %0d ns", limit_ns);
        $display("Something failed");
        $finish;
    end

    initial
    begin
        reset       = 1'b1;
        fill        = 1'b0;
        fill_src    = '0;
        fill_dst    = '0;
        fill_len    = '0;
        start       = 1'b0;
        lfsr        = 16'd9740;
        errors      = 0;
        checks      = 0;
        received    = 0;
        total_flits = 0;
        since_step  = 0;
        was_running = 1'b0;
        end_seen    = 1'b0;
        last_cycle  = '0;
        limit_ns    = 0;

        repeat (RESET_CLKS) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        compare_value("reset_cycle", 0, int'(in_cycle));
        compare_value("reset_running", 0, int'(running));
        compare_value("reset_end", 0, int'(is_end));
        compare_value("reset_eject", 0, int'(eject_valid));

        fill_random_traffic();
        limit_ns = longint'(RESET_CLKS + 2 * NUM_PKTS + 8) * CLK_NS
                 + longint'(total_flits) * NUM_NODES * 4 * CLK_NS * 2;

        @(negedge clk);
        compare_value("prestart_running", 0, int'(running));
        compare_value("prestart_end", 0, int'(is_end));
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;

        wait (is_end);
        repeat (8) @(negedge clk);   // end must hold a while
        for (int n = 0; n < NUM_NODES; n++)
            compare_value($sformatf("tails_node%0d", n), exp_tails[n], seen_tails[n]);

        $display("summary: %0d checks, %0d errors, %0d of %0d packets, %0d network cycles",
                 checks, errors, received, NUM_PKTS, in_cycle);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

//--- sim.f
hw/noc_pkg.sv
hw/payload_fifo.sv
hw/traffic_source.sv
hw/ring_router.sv
hw/sim_control.sv
hw/noc_top.sv
sim/tb_noc.sv

//--- run_sim.sh
#!/bin/sh
# build the ring NoC testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_noc -o tb_noc -f sim.f \
    && ./obj_dir/tb_noc > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "Something failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Everything OK" sim.log || { echo "no pass line in sim.log"; exit 1; }
echo "simulation passed"
